// File: Bender.yml
package:
  name: flush_ctrl

sources:
  - include_dirs:
      - .
    files:
      - flush_pkg.sv
      - flush_ctrl.sv
      - flush_dir.sv
      - flush_resize.sv
      - flush_mem_req.sv
      - flush_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - flush_props.sv
      - tb_flush.sv

// File: flush_cfg.svh
// Sizes and widths of the cache flush controller
`ifndef FLUSH_CFG_SVH
`define FLUSH_CFG_SVH

// Flush directory
`define FLUSH_ENTRIES 4
`define FLUSH_IDX_W   2

// Cache geometry for a 32-bit address and a 64-byte line
`define NLINE_W       26
`define CL_OFFSET_W   6
`define SET_W         7
`define TAG_W         (`NLINE_W - `SET_W)
`define WAYS          4
`define ACCESS_W      64
`define CL_WORDS      8
`define WORD_W        3

// Memory interface
`define MEM_DATA_W    128
`define MEM_FLITS     4
`define MEM_LEN_W     8
`define MEM_ID_W      4

// Flits held by the width converter
`define RESIZE_DEPTH  4

`endif

// File: flush_ctrl.sv
// Flush FSM sequencing the cache data reads and the writes into the width converter
`timescale 1ns/1ns
`include "flush_cfg.svh"

module flush_ctrl (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 alloc_i,
    input  flush_pkg::nline_u    alloc_nline_i,
    input  logic [`WAYS-1:0]     alloc_way_i,
    output logic                 alloc_ready_o,
    input  logic                 dir_full_i,
    input  logic                 resize_wok_i,
    input  logic                 meta_wok_i,
    output logic                 dir_alloc_o,
    output logic                 cache_rd_o,
    output flush_pkg::cache_rd_t cache_rd_cmd_o,
    output logic                 resize_w_o,
    output logic                 resize_wlast_o,
    output logic                 busy_o
);

    typedef enum logic {
        st_idle,
        st_send
    } state_e;

    state_e             state_q, state_d;
    logic [`WORD_W-1:0] word_q, word_d, word_inc;
    logic               pend_q, pend_d;
    logic               eol;
    logic [`SET_W-1:0]  set_q;
    logic [`WAYS-1:0]   way_q;

    // Next word to read, wrapping at the end of the line
    assign word_inc = (word_q == `WORD_W'(`CL_WORDS - 1)) ? '0 : word_q + 1'b1;

    // All words of the line have been read once the counter is back to zero
    assign eol = (word_q == '0);

    assign alloc_ready_o = (state_q == st_idle) & resize_wok_i & meta_wok_i & ~dir_full_i;
    assign busy_o        = (state_q == st_send);

    always_comb begin
        state_d        = state_q;
        word_d         = word_q;
        pend_d         = 1'b0;
        dir_alloc_o    = 1'b0;
        cache_rd_o     = 1'b0;
        resize_w_o     = 1'b0;
        resize_wlast_o = 1'b0;

        cache_rd_cmd_o.set  = set_q;
        cache_rd_cmd_o.word = word_q;
        cache_rd_cmd_o.way  = way_q;

        unique case (state_q)
            st_idle: begin
                // Word 0 is read in the alloc cycle itself
                if (alloc_i && alloc_ready_o) begin
                    dir_alloc_o        = 1'b1;
                    cache_rd_o         = 1'b1;
                    cache_rd_cmd_o.set = alloc_nline_i.fields.set;
                    cache_rd_cmd_o.way = alloc_way_i;
                    word_d             = word_inc;
                    pend_d             = 1'b1;
                    state_d            = st_send;
                end
            end
            st_send: begin
                // Data of the previous read is on the cache bus now
                resize_w_o     = pend_q;
                resize_wlast_o = pend_q & eol;
                if (eol) begin
                    state_d = st_idle;
                end else if (resize_wok_i) begin
                    cache_rd_o = 1'b1;
                    word_d     = word_inc;
                    pend_d     = 1'b1;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= st_idle;
            word_q  <= '0;
            pend_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            word_q  <= word_d;
            pend_q  <= pend_d;
        end
    end

    // Set and way of the line being flushed
    always_ff @(posedge clk_i) begin
        if (dir_alloc_o) begin
            set_q <= alloc_nline_i.fields.set;
            way_q <= alloc_way_i;
        end
    end

endmodule

// File: flush_dir.sv
// Flush directory with valid bits, free entry pick, line check and write acknowledgement
`timescale 1ns/1ns
`include "flush_cfg.svh"

module flush_dir (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    alloc_i,
    input  flush_pkg::nline_u       alloc_nline_i,
    output logic [`FLUSH_IDX_W-1:0] free_idx_o,
    input  flush_pkg::nline_u       check_nline_i,
    output logic                    check_hit_o,
    input  logic                    resp_valid_i,
    input  logic [`MEM_ID_W-1:0]    resp_id_i,
    output logic                    ack_o,
    output flush_pkg::nline_u       ack_nline_o,
    output logic                    empty_o,
    output logic                    full_o
);

    logic [`FLUSH_ENTRIES-1:0] valid_q;
    logic [`FLUSH_ENTRIES-1:0] valid_d;
    flush_pkg::nline_u         nline_q [`FLUSH_ENTRIES];
    logic [`FLUSH_ENTRIES-1:0] clr_bv;
    logic [`FLUSH_ENTRIES-1:0] match_bv;
    logic [`FLUSH_IDX_W-1:0]   ack_idx;

    assign full_o  = &valid_q;
    assign empty_o = ~(|valid_q);

    // Lowest free entry wins
    always_comb begin
        free_idx_o = '0;
        for (int i = `FLUSH_ENTRIES - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_idx_o = `FLUSH_IDX_W'(i);
            end
        end
    end

    // Response id decoded into a one-hot clear vector
    always_comb begin
        for (int i = 0; i < `FLUSH_ENTRIES; i++) begin
            clr_bv[i] = resp_valid_i && (resp_id_i == `MEM_ID_W'(i));
        end
    end

    // Line compare against every entry
    always_comb begin
        for (int i = 0; i < `FLUSH_ENTRIES; i++) begin
            match_bv[i] = (check_nline_i.raw == nline_q[i].raw);
        end
    end

    // An entry being acknowledged no longer hits
    assign check_hit_o = |(valid_q & ~clr_bv & match_bv);

    assign ack_idx     = resp_id_i[`FLUSH_IDX_W-1:0];
    assign ack_o       = resp_valid_i;
    assign ack_nline_o = nline_q[ack_idx];

    always_comb begin
        valid_d = valid_q & ~clr_bv;
        if (alloc_i) begin
            valid_d[free_idx_o] = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            nline_q[free_idx_o] <= alloc_nline_i;
        end
    end

endmodule

// File: flush_mem_req.sv
// Write request header FIFO and data flit formatter with last flit counter
`timescale 1ns/1ns
`include "flush_cfg.svh"

module flush_mem_req (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    meta_w_i,
    input  flush_pkg::nline_u       nline_i,
    input  logic [`FLUSH_IDX_W-1:0] id_i,
    output logic                    meta_wok_o,
    output logic                    mem_req_valid_o,
    output flush_pkg::mem_req_t     mem_req_o,
    input  logic                    mem_req_ready_i,
    input  logic                    flit_rok_i,
    input  logic [`MEM_DATA_W-1:0]  flit_i,
    output logic                    flit_r_o,
    output logic                    mem_wdata_valid_o,
    output flush_pkg::mem_wdata_t   mem_wdata_o,
    input  logic                    mem_wdata_ready_i
);

    localparam int unsigned FLIT_W = $clog2(`MEM_FLITS);

    flush_pkg::mem_req_t hdr;
    flush_pkg::mem_req_t hdr_q [2];
    logic                wr_ptr_q;
    logic                rd_ptr_q;
    logic [1:0]          cnt_q;
    logic                push;
    logic                pop;
    logic [FLIT_W-1:0]   flit_cnt_q;
    logic                flit_last;

    // Full line write, id taken from the directory entry
    always_comb begin
        hdr.addr = {nline_i.raw, {`CL_OFFSET_W{1'b0}}};
        hdr.len  = `MEM_LEN_W'(`MEM_FLITS - 1);
        hdr.id   = `MEM_ID_W'(id_i);
    end

    // Two-entry header FIFO
    assign meta_wok_o      = (cnt_q != 2'd2);
    assign mem_req_valid_o = (cnt_q != 2'd0);
    assign mem_req_o       = hdr_q[rd_ptr_q];
    assign push            = meta_w_i && meta_wok_o;
    assign pop             = mem_req_valid_o && mem_req_ready_i;

    // Flits go straight from the width converter to memory
    assign flit_last         = (flit_cnt_q == FLIT_W'(`MEM_FLITS - 1));
    assign mem_wdata_valid_o = flit_rok_i;
    assign flit_r_o          = flit_rok_i && mem_wdata_ready_i;
    assign mem_wdata_o.data  = flit_i;
    assign mem_wdata_o.last  = flit_last;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q   <= 1'b0;
            rd_ptr_q   <= 1'b0;
            cnt_q      <= 2'd0;
            flit_cnt_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            cnt_q <= cnt_q + {1'b0, push} - {1'b0, pop};
            // Count flits of the current line
            if (flit_r_o) begin
                flit_cnt_q <= flit_last ? '0 : flit_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            hdr_q[wr_ptr_q] <= hdr;
        end
    end

endmodule

// File: flush_pkg.sv
// Shared types of the flush controller: line number union, cache read and memory structs
`include "flush_cfg.svh"

package flush_pkg;

    // Line number split into tag and set index
    typedef struct packed {
        logic [`TAG_W-1:0] tag;
        logic [`SET_W-1:0] set;
    } nline_fields_t;

    // One line number word, read raw or as tag and set
    typedef union packed {
        logic [`NLINE_W-1:0] raw;
        nline_fields_t       fields;
    } nline_u;

    // Read command towards the cache data array
    typedef struct packed {
        logic [`SET_W-1:0]  set;
        logic [`WORD_W-1:0] word;
        logic [`WAYS-1:0]   way;
    } cache_rd_t;

    // Write request header
    typedef struct packed {
        logic [`NLINE_W+`CL_OFFSET_W-1:0] addr;
        logic [`MEM_LEN_W-1:0]            len;
        logic [`MEM_ID_W-1:0]             id;
    } mem_req_t;

    // Write data flit
    typedef struct packed {
        logic [`MEM_DATA_W-1:0] data;
        logic                   last;
    } mem_wdata_t;

endpackage

// File: flush_props.sv
// Bound assertions on the memory request and write data ports of the flush top level
`timescale 1ns/1ns
`include "flush_cfg.svh"

module flush_props (
    input logic                  clk_i,
    input logic                  rst_ni,
    input logic                  req_valid_i,
    input flush_pkg::mem_req_t   req_i,
    input logic                  req_ready_i,
    input logic                  wdata_valid_i,
    input flush_pkg::mem_wdata_t wdata_i,
    input logic                  wdata_ready_i
);

    localparam int unsigned FLIT_W = $clog2(`MEM_FLITS);

    logic [FLIT_W-1:0] flit_cnt_q;
    int unsigned       fail_count = 0;

    // Accepted flits modulo the line length
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            flit_cnt_q <= '0;
        end else if (wdata_valid_i && wdata_ready_i) begin
            flit_cnt_q <= flit_cnt_q + 1'b1;
        end
    end

    no_valid_in_reset: assert property (@(posedge clk_i)
        !rst_ni |-> !req_valid_i && !wdata_valid_i)
    else begin
        fail_count++;
        $error("memory valid high while reset is asserted");
    end

    // A stalled header keeps its valid and its content
    header_holds: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_i))
    else begin
        fail_count++;
        $error("write request header changed before it was accepted");
    end

    last_on_fourth: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wdata_valid_i && wdata_ready_i |->
            wdata_i.last == (flit_cnt_q == FLIT_W'(`MEM_FLITS - 1)))
    else begin
        fail_count++;
        $error("last flag does not match the flit position in the line");
    end

endmodule

bind flush_top flush_props u_props (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (mem_req_valid_o),
    .req_i         (mem_req_o),
    .req_ready_i   (mem_req_ready_i),
    .wdata_valid_i (mem_wdata_valid_o),
    .wdata_i       (mem_wdata_o),
    .wdata_ready_i (mem_wdata_ready_i)
);

// File: flush_resize.sv
// Width converter FIFO packing two cache access words into each memory flit
`timescale 1ns/1ns
`include "flush_cfg.svh"

module flush_resize (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   w_i,
    input  logic                   wlast_i,
    input  logic [`ACCESS_W-1:0]   wdata_i,
    output logic                   wok_o,
    input  logic                   r_i,
    output logic                   rok_o,
    output logic [`MEM_DATA_W-1:0] rdata_o
);

    localparam int unsigned PTR_W = $clog2(`RESIZE_DEPTH);
    localparam int unsigned CNT_W = $clog2(`RESIZE_DEPTH + 1);

    logic [`MEM_DATA_W-1:0] mem_q [`RESIZE_DEPTH];
    logic [PTR_W-1:0]       wr_ptr_q;
    logic [PTR_W-1:0]       rd_ptr_q;
    logic [CNT_W-1:0]       cnt_q;
    logic                   half_q;
    logic [CNT_W:0]         words_used;
    logic                   do_w;
    logic                   do_r;
    logic                   flit_done;

    // Occupancy counted in access words, the open flit included
    assign words_used = {cnt_q, half_q};

    // Keep room for the read already in flight in the cache
    assign wok_o = (words_used <= (CNT_W + 1)'(2 * `RESIZE_DEPTH - 2));

    assign rok_o   = (cnt_q != '0);
    assign rdata_o = mem_q[rd_ptr_q];

    assign do_w      = w_i && (cnt_q != CNT_W'(`RESIZE_DEPTH));
    assign do_r      = r_i && rok_o;
    assign flit_done = do_w && (half_q || wlast_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
            half_q   <= 1'b0;
        end else begin
            if (do_w) begin
                half_q <= ~flit_done;
            end
            if (flit_done) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_r) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (flit_done && !do_r) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (!flit_done && do_r) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // Word 0 goes to the low half of the flit
    always_ff @(posedge clk_i) begin
        if (do_w) begin
            mem_q[wr_ptr_q][half_q*`ACCESS_W +: `ACCESS_W] <= wdata_i;
        end
    end

endmodule

// File: flush_top.sv
// Flush controller top level joining FSM, directory, width converter and memory request stage
`timescale 1ns/1ns
`include "flush_cfg.svh"

module flush_top (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   alloc_i,
    input  flush_pkg::nline_u      alloc_nline_i,
    input  logic [`WAYS-1:0]       alloc_way_i,
    output logic                   alloc_ready_o,
    input  flush_pkg::nline_u      check_nline_i,
    output logic                   check_hit_o,
    output logic                   cache_rd_o,
    output flush_pkg::cache_rd_t   cache_rd_cmd_o,
    input  logic [`ACCESS_W-1:0]   cache_rd_data_i,
    output logic                   mem_req_valid_o,
    output flush_pkg::mem_req_t    mem_req_o,
    input  logic                   mem_req_ready_i,
    output logic                   mem_wdata_valid_o,
    output flush_pkg::mem_wdata_t  mem_wdata_o,
    input  logic                   mem_wdata_ready_i,
    input  logic                   mem_resp_valid_i,
    input  logic [`MEM_ID_W-1:0]   mem_resp_id_i,
    output logic                   ack_o,
    output flush_pkg::nline_u      ack_nline_o,
    output logic                   empty_o,
    output logic                   full_o,
    output logic                   busy_o
);

    logic                    dir_alloc;
    logic [`FLUSH_IDX_W-1:0] free_idx;
    logic                    resize_w;
    logic                    resize_wlast;
    logic                    resize_wok;
    logic                    resize_r;
    logic                    resize_rok;
    logic [`MEM_DATA_W-1:0]  resize_rdata;
    logic                    meta_wok;

    flush_ctrl u_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .alloc_i        (alloc_i),
        .alloc_nline_i  (alloc_nline_i),
        .alloc_way_i    (alloc_way_i),
        .alloc_ready_o  (alloc_ready_o),
        .dir_full_i     (full_o),
        .resize_wok_i   (resize_wok),
        .meta_wok_i     (meta_wok),
        .dir_alloc_o    (dir_alloc),
        .cache_rd_o     (cache_rd_o),
        .cache_rd_cmd_o (cache_rd_cmd_o),
        .resize_w_o     (resize_w),
        .resize_wlast_o (resize_wlast),
        .busy_o         (busy_o)
    );

    flush_dir u_dir (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .alloc_i       (dir_alloc),
        .alloc_nline_i (alloc_nline_i),
        .free_idx_o    (free_idx),
        .check_nline_i (check_nline_i),
        .check_hit_o   (check_hit_o),
        .resp_valid_i  (mem_resp_valid_i),
        .resp_id_i     (mem_resp_id_i),
        .ack_o         (ack_o),
        .ack_nline_o   (ack_nline_o),
        .empty_o       (empty_o),
        .full_o        (full_o)
    );

    flush_resize u_resize (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .w_i     (resize_w),
        .wlast_i (resize_wlast),
        .wdata_i (cache_rd_data_i),
        .wok_o   (resize_wok),
        .r_i     (resize_r),
        .rok_o   (resize_rok),
        .rdata_o (resize_rdata)
    );

    flush_mem_req u_mem_req (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .meta_w_i          (dir_alloc),
        .nline_i           (alloc_nline_i),
        .id_i              (free_idx),
        .meta_wok_o        (meta_wok),
        .mem_req_valid_o   (mem_req_valid_o),
        .mem_req_o         (mem_req_o),
        .mem_req_ready_i   (mem_req_ready_i),
        .flit_rok_i        (resize_rok),
        .flit_i            (resize_rdata),
        .flit_r_o          (resize_r),
        .mem_wdata_valid_o (mem_wdata_valid_o),
        .mem_wdata_o       (mem_wdata_o),
        .mem_wdata_ready_i (mem_wdata_ready_i)
    );

endmodule

// File: src.f
+incdir+.
flush_pkg.sv
flush_ctrl.sv
flush_dir.sv
flush_resize.sv
flush_mem_req.sv
flush_top.sv
flush_props.sv
tb_flush.sv

// File: tb_flush.sv
// Testbench clock generator, cache data model, memory monitor and directed flush tests
`timescale 1ns/1ns
`include "flush_cfg.svh"

module tb_clk_gen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

endmodule

module tb_flush;

    localparam int unsigned         MAX_CYCLES = 4000;
    localparam logic [`NLINE_W-1:0] LINE_A     = 26'h2abcd15;
    localparam logic [`NLINE_W-1:0] LINE_B     = 26'h1000043;

    logic                  clk_i;
    logic                  rst_ni;
    logic                  alloc_i;
    flush_pkg::nline_u     alloc_nline_i;
    logic [`WAYS-1:0]      alloc_way_i;
    logic                  alloc_ready_o;
    flush_pkg::nline_u     check_nline_i;
    logic                  check_hit_o;
    logic                  cache_rd_o;
    flush_pkg::cache_rd_t  cache_rd_cmd_o;
    logic [`ACCESS_W-1:0]  cache_rd_data_i;
    logic                  mem_req_valid_o;
    flush_pkg::mem_req_t   mem_req_o;
    logic                  mem_req_ready_i;
    logic                  mem_wdata_valid_o;
    flush_pkg::mem_wdata_t mem_wdata_o;
    logic                  mem_wdata_ready_i;
    logic                  mem_resp_valid_i;
    logic [`MEM_ID_W-1:0]  mem_resp_id_i;
    logic                  ack_o;
    flush_pkg::nline_u     ack_nline_o;
    logic                  empty_o;
    logic                  full_o;
    logic                  busy_o;

    integer                seed;
    int                    errors;
    int                    cycles;
    int                    rd_count;
    int                    exp_rd_count;
    logic                  bp_en;
    logic                  rd_seen;
    flush_pkg::cache_rd_t  cmd_seen;
    flush_pkg::mem_req_t   exp_hdr [$];
    flush_pkg::mem_wdata_t exp_flit [$];
    logic [`FLUSH_ENTRIES-1:0] model_valid;
    logic [`NLINE_W-1:0]       model_nline [`FLUSH_ENTRIES];

    tb_clk_gen u_clk (
        .clk_o (clk_i)
    );

    flush_top UUT (.*);

    // Cache word contents as a function of set, way and word index
    function automatic logic [`ACCESS_W-1:0] word_pattern(input logic [`SET_W-1:0] set,
                                                          input logic [`WAYS-1:0] way,
                                                          input logic [`WORD_W-1:0] word);
        logic [31:0] half;
        half = {5'h0, word, 4'h0, way, 1'b0, set, 8'hc3};
        return {half, ~half};
    endfunction

    function automatic int lowest_free();
        int idx;
        idx = -1;
        for (int i = 0; i < `FLUSH_ENTRIES; i++) begin
            if (idx < 0 && !model_valid[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    // Data arrives one cycle after the read strobe
    always begin
        @(negedge clk_i);
        rd_seen  = cache_rd_o;
        cmd_seen = cache_rd_cmd_o;
        @(posedge clk_i);
        #1;
        if (rd_seen) begin
            rd_count++;
            cache_rd_data_i = word_pattern(cmd_seen.set, cmd_seen.way, cmd_seen.word);
        end
    end

    always @(posedge clk_i) begin : ready_driver
        logic [31:0] rnd;
        #1;
        rnd = $random(seed);
        mem_req_ready_i   = bp_en ? rnd[0] : 1'b1;
        mem_wdata_ready_i = bp_en ? rnd[1] : 1'b1;
    end

    // Accepted headers and flits are compared in arrival order
    always @(negedge clk_i) begin : mem_monitor
        flush_pkg::mem_req_t   hdr;
        flush_pkg::mem_wdata_t flit;
        if (rst_ni && mem_req_valid_o && mem_req_ready_i) begin
            if (exp_hdr.size() == 0) begin
                report_failure("write request header sent with no flush pending");
            end else begin
                hdr = exp_hdr.pop_front();
                check_value("mem_req_o.addr", mem_req_o.addr, hdr.addr);
                check_value("mem_req_o.len", mem_req_o.len, hdr.len);
                check_value("mem_req_o.id", mem_req_o.id, hdr.id);
            end
        end
        if (rst_ni && mem_wdata_valid_o && mem_wdata_ready_i) begin
            if (exp_flit.size() == 0) begin
                report_failure("data flit sent with no flit expected");
            end else begin
                flit = exp_flit.pop_front();
                check_value("mem_wdata_o.data", mem_wdata_o.data, flit.data);
                check_value("mem_wdata_o.last", mem_wdata_o.last, flit.last);
            end
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Requests one line flush and queues the header and flits it must produce
    task automatic flush_line(input logic [`NLINE_W-1:0] nline, input logic [`WAYS-1:0] way);
        int                    idx;
        flush_pkg::mem_req_t   hdr;
        flush_pkg::mem_wdata_t flit;
        @(posedge clk_i);
        #1;
        alloc_i           = 1'b1;
        alloc_nline_i.raw = nline;
        alloc_way_i       = way;
        @(negedge clk_i);
        while (!alloc_ready_o) begin
            @(negedge clk_i);
        end
        // Every word of the line is read once
        exp_rd_count += `CL_WORDS;
        idx = lowest_free();
        if (idx < 0) begin
            report_failure("flush accepted while every directory entry is pending");
        end else begin
            model_valid[idx] = 1'b1;
            model_nline[idx] = nline;
            hdr.addr = {nline, {`CL_OFFSET_W{1'b0}}};
            hdr.len  = `MEM_LEN_W'(`MEM_FLITS - 1);
            hdr.id   = `MEM_ID_W'(idx);
            exp_hdr.push_back(hdr);
            for (int k = 0; k < `MEM_FLITS; k++) begin
                flit.data = {word_pattern(nline[`SET_W-1:0], way, `WORD_W'(2 * k + 1)),
                             word_pattern(nline[`SET_W-1:0], way, `WORD_W'(2 * k))};
                flit.last = (k == `MEM_FLITS - 1);
                exp_flit.push_back(flit);
            end
        end
        @(posedge clk_i);
        #1;
        alloc_i = 1'b0;
    endtask

    task automatic wait_drained();
        @(negedge clk_i);
        while (busy_o || exp_hdr.size() != 0 || exp_flit.size() != 0) begin
            @(negedge clk_i);
        end
        check_value("cache_rd_o count", rd_count, exp_rd_count);
    endtask

    task automatic probe_line(input logic [`NLINE_W-1:0] nline, input logic hit);
        @(posedge clk_i);
        #1;
        check_nline_i.raw = nline;
        @(negedge clk_i);
        check_value("check_hit_o", check_hit_o, hit);
    endtask

    // Memory response for one entry that must stop its line hitting in the same cycle
    task automatic send_resp(input int idx);
        @(posedge clk_i);
        #1;
        mem_resp_valid_i  = 1'b1;
        mem_resp_id_i     = `MEM_ID_W'(idx);
        check_nline_i.raw = model_nline[idx];
        @(negedge clk_i);
        check_value("ack_o", ack_o, 1'b1);
        check_value("ack_nline_o", ack_nline_o.raw, model_nline[idx]);
        check_value("check_hit_o", check_hit_o, 1'b0);
        model_valid[idx] = 1'b0;
        @(posedge clk_i);
        #1;
        mem_resp_valid_i = 1'b0;
    endtask

    task automatic reset_values();
        @(negedge clk_i);
        check_value("empty_o", empty_o, 1'b1);
        check_value("full_o", full_o, 1'b0);
        check_value("busy_o", busy_o, 1'b0);
        check_value("ack_o", ack_o, 1'b0);
        check_value("mem_req_valid_o", mem_req_valid_o, 1'b0);
        check_value("mem_wdata_valid_o", mem_wdata_valid_o, 1'b0);
        check_value("alloc_ready_o", alloc_ready_o, 1'b1);
    endtask

    task automatic single_line_flush();
        int busy_cycles;
        busy_cycles = 0;
        flush_line(LINE_A, 4'b0100);
        @(negedge clk_i);
        check_value("mem_req_valid_o", mem_req_valid_o, 1'b1);
        while (busy_o) begin
            busy_cycles++;
            @(negedge clk_i);
        end
        // Eight send cycles follow the alloc cycle
        check_value("busy_o cycles", busy_cycles, `CL_WORDS);
        wait_drained();
    endtask

    task automatic hit_and_ack();
        probe_line(LINE_A, 1'b1);
        probe_line(LINE_A ^ 26'h1, 1'b0);
        send_resp(0);
        probe_line(LINE_A, 1'b0);
        check_value("empty_o", empty_o, 1'b1);
    endtask

    task automatic directory_fill();
        int order [`FLUSH_ENTRIES];
        int j;
        int tmp;
        for (int i = 0; i < `FLUSH_ENTRIES; i++) begin
            flush_line(LINE_B + `NLINE_W'(i * 129), `WAYS'(1 << i));
            order[i] = i;
        end
        wait_drained();
        check_value("full_o", full_o, 1'b1);
        check_value("alloc_ready_o", alloc_ready_o, 1'b0);
        check_value("empty_o", empty_o, 1'b0);
        for (int i = `FLUSH_ENTRIES - 1; i > 0; i--) begin
            j        = $unsigned($random(seed)) % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < `FLUSH_ENTRIES; i++) begin
            send_resp(order[i]);
        end
        @(negedge clk_i);
        check_value("empty_o", empty_o, 1'b1);
    endtask

    task automatic backpressure_flushes();
        bp_en = 1'b1;
        for (int i = 0; i < 3; i++) begin
            flush_line(LINE_A + `NLINE_W'(i * 77 + 3), `WAYS'(8 >> i));
        end
        wait_drained();
        bp_en = 1'b0;
        for (int i = 0; i < 3; i++) begin
            send_resp(i);
        end
        @(negedge clk_i);
        check_value("empty_o", empty_o, 1'b1);
    endtask

    initial begin
        seed              = 32'h51c;
        errors            = 0;
        cycles            = 0;
        rd_count          = 0;
        exp_rd_count      = 0;
        bp_en             = 1'b0;
        model_valid       = '0;
        rst_ni            = 1'b0;
        alloc_i           = 1'b0;
        alloc_nline_i     = '0;
        alloc_way_i       = '0;
        check_nline_i     = '0;
        cache_rd_data_i   = '0;
        mem_req_ready_i   = 1'b1;
        mem_wdata_ready_i = 1'b1;
        mem_resp_valid_i  = 1'b0;
        mem_resp_id_i     = '0;
        repeat (10) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        reset_values();
        single_line_flush();
        hit_and_ack();
        directory_fill();
        backpressure_flushes();
        repeat (4) @(posedge clk_i);
        $display("Summary: %0d check errors, %0d assertion failures",
                 errors, UUT.u_props.fail_count);
        if (errors == 0 && UUT.u_props.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
